// File: common/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath widths
`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_NUM_REGS     32

// program counter
`define RV_RESET_PC     32'h0000_0000
`define RV_INST_STEP    32'd4

// major opcodes of the integer subset
`define RV_OPC_OP       7'b0110011
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_AUIPC    7'b0010111
`define RV_OPC_JAL      7'b1101111
`define RV_OPC_JALR     7'b1100111
`define RV_OPC_BRANCH   7'b1100011

// branch funct3 codes
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_BLT       3'b100
`define RV_F3_BGE       3'b101
`define RV_F3_BLTU      3'b110
`define RV_F3_BGEU      3'b111

`endif

// File: common/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND
	} alu_op_e;

	typedef enum logic [2:0] {
		KIND_ALU,
		KIND_LUI,
		KIND_AUIPC,
		KIND_JAL,
		KIND_JALR,
		KIND_BRANCH,
		KIND_NONE
	} instr_kind_e;

	typedef enum logic [1:0] {
		FETCH_REQ,
		FETCH_HOLD,
		FETCH_WAIT_REDIRECT
	} fetch_state_e;

	typedef struct packed {
		word_t pc;
		word_t inst;
	} fetch_pkt_t;

	typedef struct packed {
		word_t       pc;
		word_t       src1;
		word_t       src2;
		word_t       imm;
		alu_op_e     alu_op;
		instr_kind_e kind;
		logic        use_imm;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic        rd_wen;
	} exec_pkt_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		logic      rd_wen;
		word_t     data;
	} result_t;

	// writeback record, also the commit trace
	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t rd;
		logic      rd_wen;
		word_t     data;
	} commit_t;

	typedef struct packed {
		logic  valid;
		word_t target;
	} redirect_t;

endpackage

// File: fetch/fetch_unit.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module fetch_unit import rv_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       imem_ack_i,
	input  word_t      imem_data_i,
	input  logic       dec_ready_i,
	input  redirect_t  redirect_i,
	output logic       imem_req_o,
	output word_t      imem_addr_o,
	output logic       fetch_valid_o,
	output fetch_pkt_t fetch_o
);

	fetch_state_e state;
	word_t pc;
	logic [6:0] held_opcode;
	logic held_ctrl;
	logic take;

	// pre-decode of the held word, any jump or branch stops fetch
	assign held_opcode = fetch_o.inst[6:0];
	assign held_ctrl = (held_opcode == `RV_OPC_JAL) || (held_opcode == `RV_OPC_JALR) ||
		(held_opcode == `RV_OPC_BRANCH);

	assign take = fetch_valid_o && dec_ready_i;
	assign imem_addr_o = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH_REQ;
			pc <= `RV_RESET_PC;
			imem_req_o <= 1'b0;
			fetch_valid_o <= 1'b0;
		end else begin
			case (state)
				FETCH_REQ: begin
					if (imem_ack_i) begin
						imem_req_o <= 1'b0;
						fetch_valid_o <= 1'b1;
						state <= FETCH_HOLD;
					end else begin
						// first request after reset
						imem_req_o <= 1'b1;
					end
				end
				FETCH_HOLD: begin
					if (take) begin
						fetch_valid_o <= 1'b0;
						if (held_ctrl) begin
							state <= FETCH_WAIT_REDIRECT;
						end else begin
							pc <= pc + `RV_INST_STEP;
							imem_req_o <= 1'b1;
							state <= FETCH_REQ;
						end
					end
				end
				FETCH_WAIT_REDIRECT: begin
					if (redirect_i.valid) begin
						pc <= redirect_i.target;
						imem_req_o <= 1'b1;
						state <= FETCH_REQ;
					end
				end
				default: state <= FETCH_REQ;
			endcase
		end
	end

	// packet captured on the acknowledge edge
	always_ff @(posedge clock) begin
		if (state == FETCH_REQ && imem_ack_i) begin
			fetch_o.pc <= pc;
			fetch_o.inst <= imem_data_i;
		end
	end

	a_addr_stable: assert property (@(posedge clock) disable iff (reset)
		imem_req_o && !imem_ack_i |=> imem_req_o && $stable(imem_addr_o));

endmodule

// File: decode/regfile.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module regfile import rv_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  reg_addr_t rs1_addr_i,
	input  reg_addr_t rs2_addr_i,
	input  commit_t   wb_i,
	output word_t     rs1_data_o,
	output word_t     rs2_data_o
);

	word_t regs [`RV_NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RV_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_i.valid && wb_i.rd_wen && wb_i.rd != '0) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	// x0 reads as zero
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

	// execute drops the enable for rd 0
	a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
		wb_i.valid && wb_i.rd_wen |-> wb_i.rd != '0);

endmodule

// File: decode/decode_stage.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module decode_stage import rv_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       fetch_valid_i,
	input  fetch_pkt_t fetch_i,
	input  result_t    ex_fwd_i,
	input  commit_t    wb_i,
	output logic       dec_ready_o,
	output logic       exec_valid_o,
	output exec_pkt_t  exec_o
);

	word_t inst;
	logic [6:0] opcode;
	logic [2:0] funct3;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t rs1_data;
	word_t rs2_data;
	exec_pkt_t dec_pkt;
	logic take;

	// execute first, then writeback, then the register file
	function automatic word_t pick_src(input reg_addr_t rs, input word_t rf_data);
		word_t val;
		val = rf_data;
		if (rs != '0) begin
			if (ex_fwd_i.valid && ex_fwd_i.rd_wen && ex_fwd_i.rd == rs)
				val = ex_fwd_i.data;
			else if (wb_i.valid && wb_i.rd_wen && wb_i.rd == rs)
				val = wb_i.data;
		end
		return val;
	endfunction

	assign inst = fetch_i.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign take = fetch_valid_i && dec_ready_o;

	regfile u_regfile (
		.clock      (clock),
		.reset      (reset),
		.rs1_addr_i (rs1),
		.rs2_addr_i (rs2),
		.wb_i       (wb_i),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	always_comb begin
		dec_pkt.pc = fetch_i.pc;
		dec_pkt.src1 = pick_src(rs1, rs1_data);
		dec_pkt.src2 = pick_src(rs2, rs2_data);
		dec_pkt.imm = {{20{inst[31]}}, inst[31:20]};
		dec_pkt.alu_op = ADD;
		dec_pkt.kind = KIND_NONE;
		dec_pkt.use_imm = 1'b1;
		dec_pkt.funct3 = funct3;
		dec_pkt.rd = inst[11:7];
		dec_pkt.rd_wen = 1'b1;
		case (opcode)
			`RV_OPC_OP, `RV_OPC_OP_IMM: begin
				dec_pkt.kind = KIND_ALU;
				dec_pkt.use_imm = (opcode == `RV_OPC_OP_IMM);
				case (funct3)
					3'b000: dec_pkt.alu_op = (opcode == `RV_OPC_OP && inst[30]) ? SUB : ADD;
					3'b001: dec_pkt.alu_op = SLL;
					3'b010: dec_pkt.alu_op = SLT;
					3'b011: dec_pkt.alu_op = SLTU;
					3'b100: dec_pkt.alu_op = XOR;
					3'b101: dec_pkt.alu_op = inst[30] ? SRA : SRL;
					3'b110: dec_pkt.alu_op = OR;
					default: dec_pkt.alu_op = AND;
				endcase
			end
			`RV_OPC_LUI: begin
				dec_pkt.kind = KIND_LUI;
				dec_pkt.imm = {inst[31:12], 12'b0};
			end
			`RV_OPC_AUIPC: begin
				dec_pkt.kind = KIND_AUIPC;
				dec_pkt.imm = {inst[31:12], 12'b0};
			end
			`RV_OPC_JAL: begin
				dec_pkt.kind = KIND_JAL;
				dec_pkt.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
				// jump base is the pc itself
				dec_pkt.src1 = fetch_i.pc;
			end
			`RV_OPC_JALR: dec_pkt.kind = KIND_JALR;
			`RV_OPC_BRANCH: begin
				dec_pkt.kind = KIND_BRANCH;
				dec_pkt.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
				dec_pkt.use_imm = 1'b0;
				dec_pkt.rd_wen = 1'b0;
			end
			default: dec_pkt.rd_wen = 1'b0;
		endcase
	end

	// ready drops on a take, returns once the packet moved on
	always_ff @(posedge clock) begin
		if (reset) begin
			dec_ready_o <= 1'b1;
			exec_valid_o <= 1'b0;
		end else begin
			if (exec_valid_o)
				dec_ready_o <= 1'b1;
			else if (take)
				dec_ready_o <= 1'b0;
			if (take)
				exec_valid_o <= 1'b1;
			else if (exec_valid_o)
				exec_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take)
			exec_o <= dec_pkt;
	end

	a_single_issue: assert property (@(posedge clock) disable iff (reset)
		exec_valid_o |=> !exec_valid_o);

endmodule

// File: execute/execute_unit.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module execute_unit import rv_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      exec_valid_i,
	input  exec_pkt_t exec_i,
	output result_t   ex_fwd_o,
	output redirect_t redirect_o,
	output commit_t   commit_o
);

	word_t op_a;
	word_t op_b;
	logic [4:0] shamt;
	word_t alu_res;
	word_t link;
	word_t jump_sum;
	word_t branch_target;
	word_t result;
	logic taken;
	logic is_ctrl;
	logic wen;

	assign op_a = exec_i.src1;
	assign op_b = exec_i.use_imm ? exec_i.imm : exec_i.src2;
	assign shamt = op_b[4:0];

	always_comb begin
		case (exec_i.alu_op)
			SUB:     alu_res = op_a - op_b;
			SLL:     alu_res = op_a << shamt;
			SLT:     alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			SLTU:    alu_res = {31'b0, op_a < op_b};
			XOR:     alu_res = op_a ^ op_b;
			SRL:     alu_res = op_a >> shamt;
			SRA:     alu_res = $signed(op_a) >>> shamt;
			OR:      alu_res = op_a | op_b;
			AND:     alu_res = op_a & op_b;
			default: alu_res = op_a + op_b;
		endcase
	end

	always_comb begin
		case (exec_i.funct3)
			`RV_F3_BEQ:  taken = (op_a == op_b);
			`RV_F3_BNE:  taken = (op_a != op_b);
			`RV_F3_BLT:  taken = $signed(op_a) < $signed(op_b);
			`RV_F3_BGE:  taken = $signed(op_a) >= $signed(op_b);
			`RV_F3_BLTU: taken = op_a < op_b;
			`RV_F3_BGEU: taken = op_a >= op_b;
			default:     taken = 1'b0;
		endcase
	end

	assign link = exec_i.pc + `RV_INST_STEP;
	// src1 holds the pc for jal
	assign jump_sum = exec_i.src1 + exec_i.imm;
	assign branch_target = exec_i.pc + exec_i.imm;

	always_comb begin
		case (exec_i.kind)
			KIND_ALU:             result = alu_res;
			KIND_LUI:             result = exec_i.imm;
			KIND_AUIPC:           result = branch_target;
			KIND_JAL, KIND_JALR:  result = link;
			default:              result = '0;
		endcase
	end

	assign is_ctrl = exec_i.kind inside {KIND_JAL, KIND_JALR, KIND_BRANCH};
	assign wen = exec_i.rd_wen && exec_i.rd != '0;

	assign redirect_o.valid = exec_valid_i && is_ctrl;
	always_comb begin
		case (exec_i.kind)
			KIND_JAL:  redirect_o.target = jump_sum;
			KIND_JALR: redirect_o.target = {jump_sum[31:1], 1'b0};
			default:   redirect_o.target = taken ? branch_target : link;
		endcase
	end

	assign ex_fwd_o.valid = exec_valid_i;
	assign ex_fwd_o.rd = exec_i.rd;
	assign ex_fwd_o.rd_wen = wen;
	assign ex_fwd_o.data = result;

	always_ff @(posedge clock) begin
		if (reset)
			commit_o.valid <= 1'b0;
		else
			commit_o.valid <= exec_valid_i;
		if (exec_valid_i) begin
			commit_o.pc <= exec_i.pc;
			commit_o.rd <= exec_i.rd;
			commit_o.rd_wen <= wen;
			commit_o.data <= result;
		end
	end

	// redirect is a single pulse to a word address
	a_redirect_pulse: assert property (@(posedge clock) disable iff (reset)
		redirect_o.valid |-> redirect_o.target[1:0] == 2'b00 ##1 !redirect_o.valid);

endmodule

// File: design/core_top.sv
`timescale 1ns/10ps

module core_top import rv_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	output logic    imem_req_o,
	output word_t   imem_addr_o,
	input  logic    imem_ack_i,
	input  word_t   imem_data_i,
	output commit_t commit_o
);

	logic fetch_valid;
	fetch_pkt_t fetch_pkt;
	logic dec_ready;
	logic exec_valid;
	exec_pkt_t exec_pkt;
	result_t ex_fwd;
	redirect_t redirect;

	fetch_unit u_fetch (
		.clock         (clock),
		.reset         (reset),
		.imem_ack_i    (imem_ack_i),
		.imem_data_i   (imem_data_i),
		.dec_ready_i   (dec_ready),
		.redirect_i    (redirect),
		.imem_req_o    (imem_req_o),
		.imem_addr_o   (imem_addr_o),
		.fetch_valid_o (fetch_valid),
		.fetch_o       (fetch_pkt)
	);

	// the commit record is also the writeback port
	decode_stage u_decode (
		.clock         (clock),
		.reset         (reset),
		.fetch_valid_i (fetch_valid),
		.fetch_i       (fetch_pkt),
		.ex_fwd_i      (ex_fwd),
		.wb_i          (commit_o),
		.dec_ready_o   (dec_ready),
		.exec_valid_o  (exec_valid),
		.exec_o        (exec_pkt)
	);

	execute_unit u_execute (
		.clock        (clock),
		.reset        (reset),
		.exec_valid_i (exec_valid),
		.exec_i       (exec_pkt),
		.ex_fwd_o     (ex_fwd),
		.redirect_o   (redirect),
		.commit_o     (commit_o)
	);

endmodule

// File: test/tb_core.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module tb_core import rv_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int VEC_DEPTH = 256;
	localparam int MEM_WORDS = 64;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic imem_req;
	word_t imem_addr;
	logic imem_ack = 1'b0;
	word_t imem_data = '0;
	commit_t commit;

	logic [31:0] vectors [VEC_DEPTH];
	word_t mem [MEM_WORDS];
	int test_base [$];

	logic [31:0] rng_state = 32'h71c0_453c;
	logic busy = 1'b0;
	logic [2:0] wait_left = 3'd0;

	int checks = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int watch_cycles = 0;

	always #(CLK_PERIOD / 2) clock = ~clock;

	core_top UUT (
		.clock       (clock),
		.reset       (reset),
		.imem_req_o  (imem_req),
		.imem_addr_o (imem_addr),
		.imem_ack_i  (imem_ack),
		.imem_data_i (imem_data),
		.commit_o    (commit)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] vec_word(input int idx);
		return vectors[idx[7:0]];
	endfunction

	// memory answers each request after 1 to 4 cycles
	always @(posedge clock) begin
		if (reset) begin
			imem_ack <= 1'b0;
			busy <= 1'b0;
		end else if (imem_ack) begin
			imem_ack <= 1'b0;
		end else if (busy) begin
			if (wait_left <= 3'd1) begin
				imem_ack <= 1'b1;
				// 64-word program space
				imem_data <= mem[imem_addr[7:2]];
				busy <= 1'b0;
			end else begin
				wait_left <= wait_left - 3'd1;
			end
		end else if (imem_req) begin
			rng_state = xorshift(rng_state);
			wait_left <= {1'b0, rng_state[1:0]} + 3'd1;
			busy <= 1'b1;
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] t=%0t %s got %08h expected %08h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic run_test(input int base, input string name);
		int n_prog;
		int n_commit;
		int rec;
		int errors_before;
		logic [31:0] exp_wen;
		logic acked;
		n_prog = vec_word(base);
		n_commit = vec_word(base + 1);
		errors_before = errors;
		@(posedge clock);
		reset <= 1'b1;
		for (int i = 0; i < n_prog; i++)
			mem[i[5:0]] = vec_word(base + 2 + i);
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(posedge clock);
			if (c == RESET_CYCLES - 1)
				reset <= 1'b0;
			@(negedge clock);
			check_word("commit_o.valid", {31'b0, commit.valid}, 32'd0);
			check_word("imem_req_o", {31'b0, imem_req}, 32'd0);
		end
		// first request one cycle after reset
		@(negedge clock);
		check_word("imem_req_o", {31'b0, imem_req}, 32'd1);
		check_word("imem_addr_o", imem_addr, `RV_RESET_PC);
		check_word("commit_o.valid", {31'b0, commit.valid}, 32'd0);
		for (int k = 0; k < n_commit; k++) begin
			rec = base + 2 + n_prog + 4 * k;
			acked = 1'b0;
			do begin
				@(negedge clock);
				if (imem_ack)
					acked = 1'b1;
			end while (!commit.valid);
			assert (acked) else begin
				$display("commit_o.valid rose with no fetch acknowledge since the last commit");
				errors++;
			end
			exp_wen = vec_word(rec + 2);
			check_word("commit_o.pc", commit.pc, vec_word(rec));
			check_word("commit_o.rd_wen", {31'b0, commit.rd_wen}, exp_wen);
			if (exp_wen[0]) begin
				check_word("commit_o.rd", {27'b0, commit.rd}, vec_word(rec + 1));
				check_word("commit_o.data", commit.data, vec_word(rec + 3));
			end
		end
		tests_run++;
		if (errors == errors_before) begin
			$display("%s: %0d commits ok", name, n_commit);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	initial begin
		int base;
		int total_commits;
		base = 0;
		total_commits = 0;
		$readmemh("test/core_vectors.txt", vectors);
		while (base < VEC_DEPTH - 1 && vec_word(base) != 0) begin
			test_base.push_back(base);
			total_commits += vec_word(base + 1);
			base += 2 + vec_word(base) + 4 * vec_word(base + 1);
		end
		if (test_base.size() > 0)
			total_commits += vec_word(test_base[0] + 1);
		watch_cycles = total_commits * 10 + (test_base.size() + 1) * (RESET_CYCLES + 10);
		foreach (test_base[t])
			run_test(test_base[t], $sformatf("test %0d", t + 1));
		// same program under a new latency sequence
		if (test_base.size() > 0)
			run_test(test_base[0], "test 1 rerun");
		else
			$display("no tests found in test/core_vectors.txt");
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_run > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clock);
		$display("timeout: run did not finish within %0d cycles", watch_cycles);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tb.f
+incdir+common
common/rv_pkg.sv
fetch/fetch_unit.sv
decode/regfile.sv
decode/decode_stage.sv
execute/execute_unit.sv
design/core_top.sv
test/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_core with Verilator, fail on any error or a failing test
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_core -f tb.f -o tb_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	exit 1
fi
exit 0

// File: test/core_vectors.txt
// per test: "program_words commit_count", the program words from pc 0,
// then one commit per line: pc rd rd_wen data (all hex)
c c  // alu ops, lui, auipc
00500093 ffd00113 402081b3 00112233
001132b3 40115313 0ff0c393 12345437
00001497 00409513 0011e5b3 0000006f
00000000 01 1 00000005
00000004 02 1 fffffffd
00000008 03 1 00000008
0000000c 04 1 00000001
00000010 05 1 00000000
00000014 06 1 fffffffe
00000018 07 1 000000fa
0000001c 08 1 12345000
00000020 09 1 00001020
00000024 0a 1 00000050
00000028 0b 1 0000000d
0000002c 00 0 00000000
7 7  // dependent chain
00100093 001080b3 00108133 001101b3
40218233 003272b3 0000006f
00000000 01 1 00000001
00000004 01 1 00000002
00000008 02 1 00000004
0000000c 03 1 00000006
00000010 04 1 00000002
00000014 05 1 00000002
00000018 00 0 00000000
4 4  // writes to x0
00700013 00300093 00100133 0000006f
00000000 00 0 00000000
00000004 01 1 00000003
00000008 02 1 00000003
0000000c 00 0 00000000
e a  // branches, jal, jalr
00500093 00500113 00208463 00100193
00209463 0080026f 00200193 fff00293
0050e463 00300193 01920367 00400193
0012d463 0000006f
00000000 01 1 00000005
00000004 02 1 00000005
00000008 00 0 00000000
00000010 00 0 00000000
00000014 04 1 00000018
0000001c 05 1 ffffffff
00000020 00 0 00000000
00000028 06 1 0000002c
00000030 00 0 00000000
00000034 00 0 00000000
0 0  // end of tests
